/* rtl/pulse_macros.svh */
`ifndef PULSE_MACROS_SVH
`define PULSE_MACROS_SVH

////////////////////////////////////////////////////////////
// prf count after reset
////////////////////////////////////////////////////////////
// integer word of the prf count
`define PULSE_PRF_INT_INIT 32'h0000_0000
// fractional word, 10 s at 245.76 MHz
`define PULSE_PRF_FRAC_INIT 32'h927c_0000

// adc collect length after reset, in cycles
`define PULSE_ADC_LIMIT 32'd200

// fixed phase lengths
`define PULSE_PROCESS_CYCLES 32'd2
`define PULSE_OVERHEAD_CYCLES 32'd2

// chirp parameter block after reset
`define PULSE_CH_TUNING_INIT 32'h0000_0001
`define PULSE_CH_COUNTER_MAX_INIT 32'h0000_0fff
`define PULSE_CH_FREQ_OFFSET_INIT 32'h0000_0600
`define PULSE_CH_CTRL_INIT 32'h0000_0000

`endif

/* rtl/pulse_pkg.sv */
`default_nettype none

package pulse_pkg;

  ////////////////////////////////////////////////////////////
  // timing words
  ////////////////////////////////////////////////////////////
  // runtime timing word from the register map
  typedef logic [31:0] time_word_t;

  // integer word on top, fractional word below
  typedef logic [63:0] prf_count_t;

  // chirp parameter block, ctrl word in the top bits
  typedef struct packed {
    time_word_t ctrl_word;
    time_word_t freq_offset;
    time_word_t tuning_coef;
    time_word_t counter_max;
  } chirp_params_t;

  // sequencer phases
  // codes 5 and 6 are unused, fall back to idle
  typedef enum logic [2:0] {
    IDLE     = 3'b000,
    ACTIVE   = 3'b001,
    CHIRP    = 3'b010,
    COLLECT  = 3'b011,
    PROCESS  = 3'b100,
    OVERHEAD = 3'b111
  } pulse_state_e;

endpackage

`default_nettype wire

/* rtl/param_shadow.sv */
`default_nettype none

module param_shadow
  import pulse_pkg::*;
#(
  parameter type payload_t = time_word_t,
  parameter payload_t reset_value = '0
) (
  input  wire      aclk,
  input  wire      aresetn,
  input  payload_t din,
  output payload_t dout
);

  // two capture stages
  payload_t din_q1;
  payload_t din_q2;
  // hold register, only loads on a change
  payload_t hold_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      din_q1 <= reset_value;
      din_q2 <= reset_value;
      hold_q <= reset_value;
    end else begin
      din_q1 <= din;
      din_q2 <= din_q1;
      // change detect against the held copy
      if (din_q2 != hold_q) begin
        hold_q <= din_q2;
      end
    end
  end

  // new input value shows up three cycles later
  assign dout = hold_q;

endmodule

`default_nettype wire

/* rtl/phase_timers.sv */
`default_nettype none

`include "pulse_macros.svh"

module phase_timers
  import pulse_pkg::*;
(
  input  wire          aclk,
  input  wire          aresetn,
  input  pulse_state_e state,
  input  prf_count_t   prf_count_max,
  input  time_word_t   adc_collect_max,
  output logic         prf_expired,
  output logic         collect_last,
  output logic         process_last,
  output logic         overhead_last
);

  // down counters, one per timed phase
  prf_count_t prf_count;
  time_word_t collect_count;
  time_word_t process_count;
  time_word_t overhead_count;

  ////////////////////////////////////////////////////////////
  // prf wait
  ////////////////////////////////////////////////////////////
  // reload in idle, P+1 cycles of active down to zero
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      prf_count <= '0;
    end else if (state == IDLE) begin
      prf_count <= prf_count_max;
    end else if (state == ACTIVE && prf_count != '0) begin
      prf_count <= prf_count - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // adc collect
  ////////////////////////////////////////////////////////////
  // M cycles, last one flagged at count 1
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      collect_count <= '0;
    end else if (state == IDLE) begin
      collect_count <= adc_collect_max;
    end else if (state == COLLECT && collect_count != '0) begin
      collect_count <= collect_count - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // process and overhead
  ////////////////////////////////////////////////////////////
  // fixed lengths from the macros
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      process_count <= '0;
    end else if (state == IDLE) begin
      process_count <= `PULSE_PROCESS_CYCLES;
    end else if (state == PROCESS && process_count != '0) begin
      process_count <= process_count - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      overhead_count <= '0;
    end else if (state == IDLE) begin
      overhead_count <= `PULSE_OVERHEAD_CYCLES;
    end else if (state == OVERHEAD && overhead_count != '0) begin
      overhead_count <= overhead_count - 1'b1;
    end
  end

  // end-of-phase flags for the sequencer
  assign prf_expired   = (prf_count == '0);
  assign collect_last  = (collect_count == time_word_t'(1));
  assign process_last  = (process_count == time_word_t'(1));
  assign overhead_last = (overhead_count == time_word_t'(1));

endmodule

`default_nettype wire

/* rtl/pulse_sequencer.sv */
`default_nettype none

module pulse_sequencer
  import pulse_pkg::*;
(
  input  wire          aclk,
  input  wire          aresetn,
  // chirp side, levels and a done pulse
  input  wire          chirp_ready,
  input  wire          chirp_active,
  input  wire          chirp_done,
  // flags from the phase timers
  input  wire          prf_expired,
  input  wire          collect_last,
  input  wire          process_last,
  input  wire          overhead_last,
  output pulse_state_e state,
  output logic         chirp_init,
  output logic         chirp_enable,
  output logic         adc_enable
);

  pulse_state_e state_q;
  pulse_state_e state_d;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // one idle cycle, timers reload here
        if (chirp_ready) begin
          state_d = ACTIVE;
        end
      end
      ACTIVE: begin
        // prf elapsed, but hold until the dac is ready
        if (chirp_ready && prf_expired) begin
          state_d = CHIRP;
        end
      end
      CHIRP: begin
        if (chirp_done) begin
          state_d = COLLECT;
        end
      end
      COLLECT: begin
        if (collect_last) begin
          state_d = PROCESS;
        end
      end
      PROCESS: begin
        // no transmit path, straight to overhead
        if (process_last) begin
          state_d = OVERHEAD;
        end
      end
      OVERHEAD: begin
        if (overhead_last) begin
          state_d = IDLE;
        end
      end
      default: begin
        // unused encodings
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // chirp and adc strobes
  ////////////////////////////////////////////////////////////
  // all registered, one cycle behind the state
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      chirp_enable <= 1'b0;
      adc_enable   <= 1'b0;
      chirp_init   <= 1'b0;
    end else begin
      chirp_enable <= (state_q == CHIRP);
      // adc runs through chirp and collect
      adc_enable   <= (state_q == CHIRP) || (state_q == COLLECT);
      // single pulse as enable rises, skipped if the chirp is already running
      chirp_init   <= (state_q == CHIRP) && !chirp_active && !chirp_enable;
    end
  end

  assign state = state_q;

endmodule

`default_nettype wire

/* rtl/radar_pulse_controller.sv */
`default_nettype none

`include "pulse_macros.svh"

module radar_pulse_controller
  import pulse_pkg::*;
(
  input  wire           aclk,
  input  wire           aresetn,
  // runtime timing from the register map
  input  time_word_t    chirp_time_int,
  input  time_word_t    chirp_time_frac,
  input  time_word_t    adc_sample_time,
  // chirp parameter block, passed on to the chirp generator
  input  chirp_params_t chirp_parameters_in,
  output chirp_params_t chirp_parameters_out,
  // chirp generator handshake-free strobes
  input  wire           chirp_ready,
  input  wire           chirp_active,
  input  wire           chirp_done,
  output logic          chirp_init,
  output logic          chirp_enable,
  output logic          adc_enable
);

  ////////////////////////////////////////////////////////////
  // shadow registers
  ////////////////////////////////////////////////////////////
  // reset defaults of the three shadows
  localparam prf_count_t PRF_RESET = {`PULSE_PRF_INT_INIT, `PULSE_PRF_FRAC_INIT};
  localparam chirp_params_t CH_RESET = '{
    ctrl_word:   `PULSE_CH_CTRL_INIT,
    freq_offset: `PULSE_CH_FREQ_OFFSET_INIT,
    tuning_coef: `PULSE_CH_TUNING_INIT,
    counter_max: `PULSE_CH_COUNTER_MAX_INIT
  };

  prf_count_t   prf_time_raw;
  prf_count_t   prf_count_max;
  time_word_t   adc_collect_max;
  pulse_state_e state;
  logic         prf_expired;
  logic         collect_last;
  logic         process_last;
  logic         overhead_last;

  // both prf words share one shadow
  assign prf_time_raw = {chirp_time_int, chirp_time_frac};

  param_shadow #(.payload_t(prf_count_t), .reset_value(PRF_RESET)) u_prf_shadow (
    .aclk    (aclk),
    .aresetn (aresetn),
    .din     (prf_time_raw),
    .dout    (prf_count_max)
  );

  param_shadow #(.payload_t(time_word_t), .reset_value(`PULSE_ADC_LIMIT)) u_adc_shadow (
    .aclk    (aclk),
    .aresetn (aresetn),
    .din     (adc_sample_time),
    .dout    (adc_collect_max)
  );

  param_shadow #(.payload_t(chirp_params_t), .reset_value(CH_RESET)) u_chirp_shadow (
    .aclk    (aclk),
    .aresetn (aresetn),
    .din     (chirp_parameters_in),
    .dout    (chirp_parameters_out)
  );

  ////////////////////////////////////////////////////////////
  // timers and state machine
  ////////////////////////////////////////////////////////////
  phase_timers u_timers (
    .aclk            (aclk),
    .aresetn         (aresetn),
    .state           (state),
    .prf_count_max   (prf_count_max),
    .adc_collect_max (adc_collect_max),
    .prf_expired     (prf_expired),
    .collect_last    (collect_last),
    .process_last    (process_last),
    .overhead_last   (overhead_last)
  );

  pulse_sequencer u_sequencer (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .chirp_ready   (chirp_ready),
    .chirp_active  (chirp_active),
    .chirp_done    (chirp_done),
    .prf_expired   (prf_expired),
    .collect_last  (collect_last),
    .process_last  (process_last),
    .overhead_last (overhead_last),
    .state         (state),
    .chirp_init    (chirp_init),
    .chirp_enable  (chirp_enable),
    .adc_enable    (adc_enable)
  );

endmodule

`default_nettype wire

/* test/tb_radar_pulse_controller.sv */
`default_nettype none

`include "pulse_macros.svh"

module tb_radar_pulse_controller
  import pulse_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int IN_DELAY = 5;
  localparam int NUM_ROWS = 5;
  // ready held low before each pulse
  localparam int STALL_CYCLES = 6;
  // chirp block after reset, ctrl word on top
  localparam chirp_params_t DEFAULT_PARAMS = {`PULSE_CH_CTRL_INIT, `PULSE_CH_FREQ_OFFSET_INIT,
                                              `PULSE_CH_TUNING_INIT, `PULSE_CH_COUNTER_MAX_INIT};

  logic          aclk;
  logic          aresetn;
  time_word_t    chirp_time_int;
  time_word_t    chirp_time_frac;
  time_word_t    adc_sample_time;
  chirp_params_t chirp_parameters_in;
  chirp_params_t chirp_parameters_out;
  logic          chirp_ready;
  logic          chirp_active;
  logic          chirp_done;
  logic          chirp_init;
  logic          chirp_enable;
  logic          adc_enable;

  ////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////
  // prf fraction, adc length, done delay (from 1), active held
  int            row_prf [NUM_ROWS];
  int            row_adc [NUM_ROWS];
  int            row_done [NUM_ROWS];
  logic          row_active [NUM_ROWS];
  chirp_params_t row_params [NUM_ROWS];
  int            seed;
  logic          table_loaded;

  // monitor state, updated once per sample point
  int   cycle;
  int   error_count;
  int   en_run;
  int   adc_run;
  int   rise_cycle;
  int   cur_adc;
  int   cur_done;
  logic en_prev;
  logic adc_prev;
  logic rise_seen;
  logic adc_fall_seen;

  radar_pulse_controller UUT (
    .aclk                 (aclk),
    .aresetn              (aresetn),
    .chirp_time_int       (chirp_time_int),
    .chirp_time_frac      (chirp_time_frac),
    .adc_sample_time      (adc_sample_time),
    .chirp_parameters_in  (chirp_parameters_in),
    .chirp_parameters_out (chirp_parameters_out),
    .chirp_ready          (chirp_ready),
    .chirp_active         (chirp_active),
    .chirp_done           (chirp_done),
    .chirp_init           (chirp_init),
    .chirp_enable         (chirp_enable),
    .adc_enable           (adc_enable)
  );

  initial aclk = 1'b0;
  always #(CLK_PERIOD / 2) aclk = ~aclk;

  task automatic check_equal(input string name, input logic [127:0] got,
                             input logic [127:0] expected);
    if (got !== expected) begin
      error_count = error_count + 1;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic set_row(input int r, input int prf, input int adc, input int done_delay,
                         input logic active);
    row_prf[r] = prf;
    row_adc[r] = adc;
    row_done[r] = done_delay;
    row_active[r] = active;
    row_params[r] = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  // one pulse period from the phase lengths
  function automatic int expected_period(input int r);
    expected_period = 1 + (row_prf[r] + 1) + (row_done[r] + 1) + row_adc[r]
                      + `PULSE_PROCESS_CYCLES + `PULSE_OVERHEAD_CYCLES;
  endfunction

  ////////////////////////////////////////////////////////////
  // strobe monitor and chirp responder
  ////////////////////////////////////////////////////////////
  task automatic watch_strobes();
    // init only on the rising cycle, and only when the chirp is idle
    check_equal("chirp_init", chirp_init, chirp_enable && !en_prev && !chirp_active);
    if (chirp_enable) en_run = en_run + 1;
    if (adc_enable) adc_run = adc_run + 1;
    if (chirp_enable && !en_prev) begin
      rise_seen = 1'b1;
      rise_cycle = cycle;
    end
    if (!chirp_enable && en_prev) begin
      check_equal("chirp_enable high cycles", en_run, cur_done + 1);
      en_run = 0;
    end
    if (!adc_enable && adc_prev) begin
      check_equal("adc_enable high cycles", adc_run, cur_done + 1 + cur_adc);
      adc_run = 0;
      adc_fall_seen = 1'b1;
    end
    // done pulse seen by the dut at the next edge
    chirp_done = chirp_enable && (en_run == cur_done);
    en_prev = chirp_enable;
    adc_prev = adc_enable;
  endtask

  // inputs change and outputs are read 5 units after the edge
  task automatic step_cycle();
    @(posedge aclk);
    #(IN_DELAY);
    cycle = cycle + 1;
    watch_strobes();
  endtask

  task automatic wait_chirp_rise();
    rise_seen = 1'b0;
    while (!rise_seen) step_cycle();
  endtask

  // adc drops on entry to process, idle again after overhead
  task automatic wait_pulse_end();
    adc_fall_seen = 1'b0;
    while (!adc_fall_seen) step_cycle();
    repeat (`PULSE_PROCESS_CYCLES + `PULSE_OVERHEAD_CYCLES) step_cycle();
  endtask

  // new row while the sequencer sits in idle
  task automatic apply_row(input int r);
    chirp_params_t old_params;
    // previous row's block, reset defaults before the first row
    if (r == 0) begin
      old_params = DEFAULT_PARAMS;
    end else begin
      old_params = row_params[r - 1];
    end
    chirp_time_int = '0;
    chirp_time_frac = row_prf[r];
    adc_sample_time = row_adc[r];
    chirp_active = row_active[r];
    chirp_parameters_in = row_params[r];
    cur_adc = row_adc[r];
    cur_done = row_done[r];
    // shadow output moves on the third cycle
    for (int k = 1; k <= 4; k++) begin
      step_cycle();
      if (k < 3) begin
        check_equal("chirp_parameters_out", chirp_parameters_out, old_params);
      end else begin
        check_equal("chirp_parameters_out", chirp_parameters_out, row_params[r]);
      end
      check_equal("chirp_enable", chirp_enable, 1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int start_cycle;
    int first_rise;
    int last;
    aresetn = 1'b0;
    chirp_time_int = `PULSE_PRF_INT_INIT;
    chirp_time_frac = `PULSE_PRF_FRAC_INIT;
    adc_sample_time = `PULSE_ADC_LIMIT;
    chirp_parameters_in = DEFAULT_PARAMS;
    chirp_ready = 1'b0;
    chirp_active = 1'b0;
    chirp_done = 1'b0;
    cycle = 0;
    error_count = 0;
    en_run = 0;
    adc_run = 0;
    rise_cycle = 0;
    cur_adc = 0;
    cur_done = 0;
    en_prev = 1'b0;
    adc_prev = 1'b0;
    rise_seen = 1'b0;
    adc_fall_seen = 1'b0;
    seed = 86090;
    set_row(0, 3, 4, 1, 1'b0);
    set_row(1, 0, 1, 3, 1'b0);
    set_row(2, 9, 6, 2, 1'b1);
    set_row(3, 5, 2, 4, 1'b0);
    set_row(4, 1, 10, 1, 1'b1);
    table_loaded = 1'b1;
    repeat (3) @(posedge aclk);
    #(IN_DELAY);
    aresetn = 1'b1;
    // reset defaults, held while ready is low
    for (int k = 0; k < 4; k++) begin
      check_equal("chirp_init", chirp_init, 1'b0);
      check_equal("chirp_enable", chirp_enable, 1'b0);
      check_equal("adc_enable", adc_enable, 1'b0);
      check_equal("chirp_parameters_out", chirp_parameters_out, DEFAULT_PARAMS);
      step_cycle();
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
      repeat (STALL_CYCLES) begin
        step_cycle();
        check_equal("chirp_enable", chirp_enable, 1'b0);
      end
      // idle, prf wait, then the registered enable
      chirp_ready = 1'b1;
      start_cycle = cycle;
      wait_chirp_rise();
      check_equal("cycles ready to chirp_enable", rise_cycle - start_cycle,
                  1 + (row_prf[r] + 1) + 1);
      first_rise = rise_cycle;
      wait_chirp_rise();
      check_equal("chirp_enable period", rise_cycle - first_rise, expected_period(r));
      chirp_ready = 1'b0;
      wait_pulse_end();
    end
    // ready drops during the prf wait, counter runs out and waits
    last = NUM_ROWS - 1;
    chirp_ready = 1'b1;
    step_cycle();
    chirp_ready = 1'b0;
    repeat (row_prf[last] + 8) begin
      step_cycle();
      check_equal("chirp_enable", chirp_enable, 1'b0);
    end
    chirp_ready = 1'b1;
    start_cycle = cycle;
    wait_chirp_rise();
    check_equal("cycles ready to chirp_enable", rise_cycle - start_cycle, 2);
    chirp_ready = 1'b0;
    wait_pulse_end();
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // budget of three periods per row plus setup
  initial begin : watchdog
    int budget;
    wait (table_loaded === 1'b1);
    budget = 100;
    for (int r = 0; r < NUM_ROWS; r++) begin
      budget = budget + 3 * expected_period(r) + 20;
    end
    #(budget * CLK_PERIOD);
    $display("timeout: sequencer did not finish its pulses within %0d cycles", budget);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/pulse_pkg.sv
rtl/param_shadow.sv
rtl/phase_timers.sv
rtl/pulse_sequencer.sv
rtl/radar_pulse_controller.sv
test/tb_radar_pulse_controller.sv

/* Bender.yml */
package:
  name: radar_pulse_controller

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pulse_pkg.sv
      - rtl/param_shadow.sv
      - rtl/phase_timers.sv
      - rtl/pulse_sequencer.sv
      - rtl/radar_pulse_controller.sv
      - target: test
        files:
          - test/tb_radar_pulse_controller.sv
